//--- design/inverter_settings.svh
`ifndef INVERTER_SETTINGS_SVH
`define INVERTER_SETTINGS_SVH

////////////////////////////////////////
// datapath widths
////////////////////////////////////////
`define SAMPLE_W 16
`define CMP_W 10

////////////////////////////////////////
// triangle carrier, period is 2*CARRIER_MAX
////////////////////////////////////////
`define CARRIER_MAX 250
`define CARRIER_MID 125

// gain stands in for 1/vdc
`define MOD_GAIN 160
`define MOD_SHIFT 15

// 8 frames
`define FIFO_DEPTH_LOG2 3

`endif

//--- design/inverter_pkg.sv
`include "inverter_settings.svh"

package inverter_pkg;

	////////////////////////////////////////
	// scalar types
	////////////////////////////////////////

	// signed phase voltage reference
	typedef logic signed [`SAMPLE_W-1:0] sample_t;

	// compare value, also the carrier count
	typedef logic [`CMP_W-1:0] cmp_t;

	////////////////////////////////////////
	// one modulation frame
	////////////////////////////////////////

	// three compare values, phase a in the top bits
	typedef struct packed {
		cmp_t cmp_a;
		cmp_t cmp_b;
		cmp_t cmp_c;
	} phase_frame_t;

endpackage

//--- design/reference_scaler.sv
`timescale 1ns/1ps
`include "inverter_settings.svh"

module reference_scaler (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        sample_strobe,
	input  inverter_pkg::sample_t       va,
	input  inverter_pkg::sample_t       vb,
	input  inverter_pkg::sample_t       vc,
	input  logic                        full,
	output logic                        push,
	output inverter_pkg::phase_frame_t  frame,
	output logic                        sample_overrun
);

	////////////////////////////////////////
	// scaling constants
	////////////////////////////////////////

	// sample width plus a signed 9 bit gain
	localparam int PROD_W = `SAMPLE_W + 9;

	localparam logic signed [PROD_W-1:0] GAIN = `MOD_GAIN;
	localparam logic signed [PROD_W-1:0] MID = `CARRIER_MID;
	localparam logic signed [PROD_W-1:0] TOP = `CARRIER_MAX;

	inverter_pkg::phase_frame_t frame_q;
	logic frame_valid;
	logic overrun_q;

	// gain, shift, offset to carrier middle, clamp
	function automatic inverter_pkg::cmp_t scale_phase(input inverter_pkg::sample_t s);
		logic signed [PROD_W-1:0] prod;
		logic signed [PROD_W-1:0] shifted;
		logic signed [PROD_W-1:0] offset;
		inverter_pkg::cmp_t result;
		prod = s * GAIN;
		shifted = prod >>> `MOD_SHIFT;
		offset = shifted + MID;
		if (offset < 0) begin
			result = '0;
		end else if (offset > TOP) begin
			result = TOP[`CMP_W-1:0];
		end else begin
			result = offset[`CMP_W-1:0];
		end
		return result;
	endfunction

	////////////////////////////////////////
	// capture and scale
	////////////////////////////////////////

	// all three phases land in one stage
	always_ff @(posedge clk) begin
		if (sample_strobe) begin
			frame_q.cmp_a <= scale_phase(va);
			frame_q.cmp_b <= scale_phase(vb);
			frame_q.cmp_c <= scale_phase(vc);
		end
	end

	// one pending frame per strobe, live for a single cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			frame_valid <= 1'b0;
		end else begin
			frame_valid <= sample_strobe;
		end
	end

	////////////////////////////////////////
	// push or drop
	////////////////////////////////////////

	// full is sampled in the push cycle, so earlier pushes are counted
	assign push = frame_valid & ~full;
	assign frame = frame_q;

	// dropped frame, sticky until reset
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			overrun_q <= 1'b0;
		end else if (frame_valid && full) begin
			overrun_q <= 1'b1;
		end
	end

	assign sample_overrun = overrun_q;

endmodule

//--- design/frame_fifo.sv
`timescale 1ns/1ps
`include "inverter_settings.svh"

module frame_fifo (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        push,
	input  inverter_pkg::phase_frame_t  wr_frame,
	input  logic                        pop,
	output inverter_pkg::phase_frame_t  rd_frame,
	output logic                        full,
	output logic                        empty
);

	localparam int AW = `FIFO_DEPTH_LOG2;
	localparam int DEPTH = 1 << AW;

	////////////////////////////////////////
	// storage
	////////////////////////////////////////

	inverter_pkg::phase_frame_t mem [DEPTH];

	// extra top bit tells full from empty
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;

	logic addr_match;
	logic wrap_differs;

	// the scaler already checks full before pushing
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr[AW-1:0]] <= wr_frame;
		end
	end

	////////////////////////////////////////
	// pointers
	////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
		end else if (push) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// modulator pops only while not empty
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_ptr <= '0;
		end else if (pop) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	////////////////////////////////////////
	// status and show-ahead read
	////////////////////////////////////////

	assign addr_match = (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign wrap_differs = (wr_ptr[AW] != rd_ptr[AW]);

	assign empty = addr_match & ~wrap_differs;
	assign full = addr_match & wrap_differs;

	// head frame valid whenever empty is low
	assign rd_frame = mem[rd_ptr[AW-1:0]];

endmodule

//--- design/pwm_modulator.sv
`timescale 1ns/1ps
`include "inverter_settings.svh"

module pwm_modulator (
	input  logic                        clk,
	input  logic                        rst,
	input  inverter_pkg::phase_frame_t  frame,
	input  logic                        empty,
	output logic                        pop,
	output logic                        gate_a_hi,
	output logic                        gate_a_lo,
	output logic                        gate_b_hi,
	output logic                        gate_b_lo,
	output logic                        gate_c_hi,
	output logic                        gate_c_lo,
	output logic                        period_start
);

	localparam inverter_pkg::cmp_t CARRIER_TOP = `CARRIER_MAX;

	inverter_pkg::cmp_t carrier;
	logic count_up;

	inverter_pkg::phase_frame_t cmp_q;

	logic hi_a;
	logic hi_b;
	logic hi_c;

	////////////////////////////////////////
	// triangle carrier
	////////////////////////////////////////

	// 0 up to top, back down to 1, then 0 again
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			carrier <= '0;
			count_up <= 1'b1;
		end else if (count_up) begin
			if (carrier == CARRIER_TOP) begin
				carrier <= CARRIER_TOP - 1'b1;
				count_up <= 1'b0;
			end else begin
				carrier <= carrier + 1'b1;
			end
		end else begin
			if (carrier == inverter_pkg::cmp_t'(1)) begin
				// turn around at the valley
				carrier <= '0;
				count_up <= 1'b1;
			end else begin
				carrier <= carrier - 1'b1;
			end
		end
	end

	// valley marks the period boundary
	assign period_start = (carrier == '0);

	////////////////////////////////////////
	// frame load at the valley
	////////////////////////////////////////

	assign pop = period_start & ~empty;

	// no new frame means the last values carry on
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cmp_q <= '0;
		end else if (pop) begin
			cmp_q <= frame;
		end
	end

	////////////////////////////////////////
	// comparators
	////////////////////////////////////////

	// high side on while compare value is above the carrier
	assign hi_a = (cmp_q.cmp_a > carrier);
	assign hi_b = (cmp_q.cmp_b > carrier);
	assign hi_c = (cmp_q.cmp_c > carrier);

	assign gate_a_hi = hi_a;
	assign gate_b_hi = hi_b;
	assign gate_c_hi = hi_c;

	// complementary low side, no dead time
	assign gate_a_lo = ~hi_a;
	assign gate_b_lo = ~hi_b;
	assign gate_c_lo = ~hi_c;

endmodule

//--- design/inverter_pwm_top.sv
`timescale 1ns/1ps

module inverter_pwm_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   sample_strobe,
	input  inverter_pkg::sample_t  va,
	input  inverter_pkg::sample_t  vb,
	input  inverter_pkg::sample_t  vc,
	output logic                   gate_a_hi,
	output logic                   gate_a_lo,
	output logic                   gate_b_hi,
	output logic                   gate_b_lo,
	output logic                   gate_c_hi,
	output logic                   gate_c_lo,
	output logic                   period_start,
	output logic                   sample_overrun
);

	// scaler to fifo
	logic push;
	logic full;
	inverter_pkg::phase_frame_t wr_frame;

	// fifo to modulator
	logic pop;
	logic empty;
	inverter_pkg::phase_frame_t rd_frame;

	////////////////////////////////////////
	// reference capture and scaling
	////////////////////////////////////////

	reference_scaler u_reference_scaler (
		.clk            (clk),
		.rst            (rst),
		.sample_strobe  (sample_strobe),
		.va             (va),
		.vb             (vb),
		.vc             (vc),
		.full           (full),
		.push           (push),
		.frame          (wr_frame),
		.sample_overrun (sample_overrun)
	);

	////////////////////////////////////////
	// frame buffer
	////////////////////////////////////////

	frame_fifo u_frame_fifo (
		.clk      (clk),
		.rst      (rst),
		.push     (push),
		.wr_frame (wr_frame),
		.pop      (pop),
		.rd_frame (rd_frame),
		.full     (full),
		.empty    (empty)
	);

	////////////////////////////////////////
	// carrier and gate drive
	////////////////////////////////////////

	pwm_modulator u_pwm_modulator (
		.clk          (clk),
		.rst          (rst),
		.frame        (rd_frame),
		.empty        (empty),
		.pop          (pop),
		.gate_a_hi    (gate_a_hi),
		.gate_a_lo    (gate_a_lo),
		.gate_b_hi    (gate_b_hi),
		.gate_b_lo    (gate_b_lo),
		.gate_c_hi    (gate_c_hi),
		.gate_c_lo    (gate_c_lo),
		.period_start (period_start)
	);

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic rst
);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// held over ten rising edges, released on a falling edge
	initial begin
		rst = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

//--- verification/tb_inverter_pwm.sv
`timescale 1ns/1ps
`include "inverter_settings.svh"

module tb_inverter_pwm;

	localparam int NUM_CASES = 16;
	localparam int PERIOD = 2 * `CARRIER_MAX;
	localparam int TIMEOUT_CYCLES = (NUM_CASES + 12) * PERIOD * 2;
	localparam int MAX_IDLE = 6;

	logic clk;
	logic rst;
	logic sample_strobe;
	inverter_pkg::sample_t va;
	inverter_pkg::sample_t vb;
	inverter_pkg::sample_t vc;
	logic gate_a_hi;
	logic gate_a_lo;
	logic gate_b_hi;
	logic gate_b_lo;
	logic gate_c_hi;
	logic gate_c_lo;
	logic period_start;
	logic sample_overrun;

	// six words per case, three samples then three counts
	logic [15:0] case_mem [0:NUM_CASES*6-1];

	int error_count = 0;
	int tests_run = 0;
	int tests_clean = 0;
	int cycle_count = 0;
	int period_idx = 0;
	int run_a = 0;
	int run_b = 0;
	int run_c = 0;
	inverter_pkg::cmp_t last_a = '0;
	inverter_pkg::cmp_t last_b = '0;
	inverter_pkg::cmp_t last_c = '0;

	tb_clock_gen u_clock_gen (
		.clk (clk),
		.rst (rst)
	);

	inverter_pwm_top u_inverter_pwm_top (
		.clk            (clk),
		.rst            (rst),
		.sample_strobe  (sample_strobe),
		.va             (va),
		.vb             (vb),
		.vc             (vc),
		.gate_a_hi      (gate_a_hi),
		.gate_a_lo      (gate_a_lo),
		.gate_b_hi      (gate_b_hi),
		.gate_b_lo      (gate_b_lo),
		.gate_c_hi      (gate_c_hi),
		.gate_c_lo      (gate_c_lo),
		.period_start   (period_start),
		.sample_overrun (sample_overrun)
	);

	////////////////////////////////////////
	// compare and bookkeeping
	////////////////////////////////////////

	task automatic check_count(input string name, input inverter_pkg::cmp_t got,
			input inverter_pkg::cmp_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_counts(input inverter_pkg::cmp_t ea, input inverter_pkg::cmp_t eb,
			input inverter_pkg::cmp_t ec);
		check_count("gate_a_hi count", last_a, ea);
		check_count("gate_b_hi count", last_b, eb);
		check_count("gate_c_hi count", last_c, ec);
	endtask

	// phase 0..2 picks the a, b or c count of case k
	function automatic inverter_pkg::cmp_t exp_count(input int k, input int phase);
		return case_mem[k*6 + 3 + phase][`CMP_W-1:0];
	endfunction

	task automatic finish_test(input string label, input int err_before);
		tests_run++;
		if (error_count == err_before) begin
			tests_clean++;
			$display("%s: ok", label);
		end else begin
			$display("%s: %0d errors", label, error_count - err_before);
		end
	endtask

	// returns on the falling edge after the n-th further valley
	task automatic wait_periods(input int n);
		int target;
		target = period_idx + n;
		while (period_idx < target) begin
			@(negedge clk);
		end
	endtask

	task automatic drive_case(input int k);
		va = case_mem[k*6];
		vb = case_mem[k*6 + 1];
		vc = case_mem[k*6 + 2];
		sample_strobe = 1'b1;
	endtask

	////////////////////////////////////////
	// gate monitor
	////////////////////////////////////////

	// counts run from the cycle after a valley up to the next valley
	always @(posedge clk) begin
		if (rst) begin
			run_a = 0;
			run_b = 0;
			run_c = 0;
		end else begin
			check_flag("gate_a_lo", gate_a_lo, ~gate_a_hi);
			check_flag("gate_b_lo", gate_b_lo, ~gate_b_hi);
			check_flag("gate_c_lo", gate_c_lo, ~gate_c_hi);
			run_a = run_a + int'(gate_a_hi);
			run_b = run_b + int'(gate_b_hi);
			run_c = run_c + int'(gate_c_hi);
			if (period_start) begin
				last_a = inverter_pkg::cmp_t'(run_a);
				last_b = inverter_pkg::cmp_t'(run_b);
				last_c = inverter_pkg::cmp_t'(run_c);
				run_a = 0;
				run_b = 0;
				run_c = 0;
				period_idx++;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("test failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		int k;
		int j;
		int idle;
		int idle_used;
		int err_before;
		inverter_pkg::cmp_t prev_a;
		inverter_pkg::cmp_t prev_b;
		inverter_pkg::cmp_t prev_c;
		sample_strobe = 1'b0;
		va = '0;
		vb = '0;
		vc = '0;
		$readmemh("verification/modulator_cases.txt", case_mem);
		void'($urandom(32'h82bce00c));
		// reset only moves on falling edges, so look at it on rising ones
		@(posedge clk);
		while (rst) begin
			@(posedge clk);
		end
		@(negedge clk);

		// a full period on the reset compare values
		err_before = error_count;
		wait_periods(2);
		check_counts('0, '0, '0);
		check_flag("sample_overrun", sample_overrun, 1'b0);
		finish_test("reset state", err_before);

		prev_a = '0;
		prev_b = '0;
		prev_c = '0;
		idle_used = 0;
		for (k = 0; k < NUM_CASES; k++) begin
			err_before = error_count;
			drive_case(k);
			@(negedge clk);
			sample_strobe = 1'b0;
			// frame waits in the fifo, old values hold
			wait_periods(1);
			check_counts(prev_a, prev_b, prev_c);
			wait_periods(1);
			check_counts(exp_count(k, 0), exp_count(k, 1), exp_count(k, 2));
			idle = int'($urandom % 2);
			if (idle_used + idle > MAX_IDLE) begin
				idle = 0;
			end
			idle_used += idle;
			repeat (idle) begin
				wait_periods(1);
				check_counts(exp_count(k, 0), exp_count(k, 1), exp_count(k, 2));
			end
			prev_a = exp_count(k, 0);
			prev_b = exp_count(k, 1);
			prev_c = exp_count(k, 2);
			finish_test($sformatf("case %0d", k), err_before);
		end

		// ten strobes into an eight frame fifo
		err_before = error_count;
		for (j = 0; j < 10; j++) begin
			drive_case(j);
			@(negedge clk);
		end
		sample_strobe = 1'b0;
		wait_periods(1);
		for (j = 0; j < 8; j++) begin
			wait_periods(1);
			check_counts(exp_count(j, 0), exp_count(j, 1), exp_count(j, 2));
		end
		// last two were dropped so the eighth frame holds
		wait_periods(1);
		check_counts(exp_count(7, 0), exp_count(7, 1), exp_count(7, 2));
		check_flag("sample_overrun", sample_overrun, 1'b1);
		finish_test("order and overrun", err_before);

		$display("%0d tests run, %0d clean, %0d check errors", tests_run, tests_clean,
			error_count);
		if (error_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- verification/modulator_cases.txt
// va vb vc: signed phase samples in hex
// then expected high-side counts per period for phases a, b, c in hex
0000 0000 0000  0f9 0f9 0f9
0400 fc00 0000  103 0ef 0f9
7fff 8000 0000  1f3 000 0f9
6400 9c00 00cd  1f3 000 0fb
9ccd 6334 ffff  001 1f1 0f7
2710 d8f0 0064  159 097 0f9
4e20 b1e0 ff9c  1bb 035 0f7
0bb8 f448 3a98  115 0db 18b
c568 7530 0000  065 1f3 0f9
8000 8000 8000  000 000 000
7fff 7fff 7fff  1f3 1f3 1f3
ffff 0001 0400  0f7 0f9 103
3a98 0bb8 f448  18b 115 0db
00cd fc00 2710  0fb 0ef 159
b1e0 4e20 d8f0  035 1bb 097
6334 9ccd c568  1f1 001 065

//--- all.f
+incdir+design
design/inverter_pkg.sv
design/reference_scaler.sv
design/frame_fifo.sv
design/pwm_modulator.sv
design/inverter_pwm_top.sv
verification/tb_clock_gen.sv
verification/tb_inverter_pwm.sv

//--- run_sim.sh
#!/bin/sh
# build and run the inverter pwm testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f all.f \
	--top-module tb_inverter_pwm -o sim_inverter_pwm
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/sim_inverter_pwm)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "test passed"; then
	exit 0
fi
exit 1
